/* build.f */
common/debug_pkg.sv
uart/uart_rx.sv
uart/uart_tx.sv
rtl/acc_core.sv
rtl/state_collector.sv
rtl/debug_controller.sv
rtl/debug_top.sv
verification/debug_checker.sv
verification/debug_properties.sv
verification/debug_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Compile and run the debug unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

log_file=sim.log

if ! verilator --binary --timing --assert -j 0 --top-module debug_tb \
	-f build.f -o debug_sim; then
	echo "Verilator compile step did not succeed"
	exit 1
fi

if ! ./obj_dir/debug_sim > "$log_file" 2>&1; then
	cat "$log_file"
	echo "Simulation exited with an error status"
	exit 1
fi

cat "$log_file"

if grep -q "All tests passed" "$log_file"; then
	exit 0
fi

echo "Pass message not found in $log_file"
exit 1

/* verification/debug_tb.sv */
`timescale 1ns/1ns

module debug_tb;

	localparam int clks_per_bit  = 8;
	localparam int n_tests       = 8;
	localparam int reply_timeout = 4000;

	logic clk;
	logic rst_n;
	logic rx;
	logic tx;

	string test_names [n_tests];
	logic [7:0] cmd_tab [n_tests][$];
	logic [7:0] exp_tab [n_tests][$];

	int pass_count;
	int fail_count;
	bit timed_out;

	debug_top #(
		.clks_per_bit(clks_per_bit),
		.prog_depth(32)
	) u_debug_top (
		.clk(clk),
		.rst_n(rst_n),
		.rx(rx),
		.tx(tx)
	);

	debug_checker #(
		.clks_per_bit(clks_per_bit)
	) u_checker (
		.clk(clk),
		.rst_n(rst_n),
		.tx(tx)
	);

	bind debug_controller debug_properties u_debug_properties (
		.clk(clk),
		.rst_n(rst_n),
		.tx_start(tx_start),
		.tx_done(tx_done),
		.core_enable(core_enable),
		.load_we(load_we)
	);

	always #20 clk = ~clk;

	// Opcode in bits 7 to 5, operand below
	function automatic logic [7:0] encode(input logic [2:0] op, input logic [4:0] operand);
		return {op, operand};
	endfunction

	//////////////////////////////
	// Stimulus table
	//////////////////////////////

	task automatic build_table();
		test_names[0] = "step_first";
		cmd_tab[0] = '{debug_pkg::cmd_load, 8'd3, encode(debug_pkg::op_ldi, 5'd5),
			encode(debug_pkg::op_str, 5'd1), encode(debug_pkg::op_halt, 5'd0),
			debug_pkg::cmd_step};
		exp_tab[0] = '{8'd1, 8'd5, 8'd0, 8'd0, 8'd0, 8'd0};

		test_names[1] = "step_second";
		cmd_tab[1] = '{debug_pkg::cmd_step};
		exp_tab[1] = '{8'd2, 8'd5, 8'd0, 8'd5, 8'd0, 8'd0};

		test_names[2] = "run_add";
		cmd_tab[2] = '{debug_pkg::cmd_load, 8'd6, encode(debug_pkg::op_ldi, 5'd7),
			encode(debug_pkg::op_str, 5'd0), encode(debug_pkg::op_ldi, 5'd3),
			encode(debug_pkg::op_add, 5'd0), encode(debug_pkg::op_str, 5'd2),
			encode(debug_pkg::op_halt, 5'd0), debug_pkg::cmd_run};
		exp_tab[2] = '{8'd5, 8'd10, 8'd7, 8'd0, 8'd10, 8'd0};

		// Loop on jnz until acc counts down to zero
		test_names[3] = "run_countdown";
		cmd_tab[3] = '{debug_pkg::cmd_load, 8'd6, encode(debug_pkg::op_ldi, 5'd1),
			encode(debug_pkg::op_str, 5'd3), encode(debug_pkg::op_ldi, 5'd4),
			encode(debug_pkg::op_sub, 5'd3), encode(debug_pkg::op_jnz, 5'd3),
			encode(debug_pkg::op_halt, 5'd0), debug_pkg::cmd_run};
		exp_tab[3] = '{8'd5, 8'd0, 8'd0, 8'd0, 8'd0, 8'd1};

		test_names[4] = "unknown_cmd";
		cmd_tab[4] = '{8'h41};
		exp_tab[4] = '{8'hEE};

		// Core still halted from the countdown
		test_names[5] = "step_after_error";
		cmd_tab[5] = '{debug_pkg::cmd_step};
		exp_tab[5] = '{8'd5, 8'd0, 8'd0, 8'd0, 8'd0, 8'd1};

		test_names[6] = "step_halted";
		cmd_tab[6] = '{debug_pkg::cmd_step};
		exp_tab[6] = '{8'd5, 8'd0, 8'd0, 8'd0, 8'd0, 8'd1};

		test_names[7] = "reload_run";
		cmd_tab[7] = '{debug_pkg::cmd_load, 8'd1, encode(debug_pkg::op_halt, 5'd0),
			debug_pkg::cmd_run};
		exp_tab[7] = '{8'd0, 8'd0, 8'd0, 8'd0, 8'd0, 8'd0};
	endtask

	//////////////////////////////
	// Serial driver
	//////////////////////////////

	// Called 2 ns after a rising edge, returns at the same offset
	task automatic drive_bit(input logic value);
		rx = value;
		repeat (clks_per_bit) @(posedge clk);
		#2;
	endtask

	task automatic send_byte(input logic [7:0] value);
		drive_bit(1'b0);
		for (int i = 0; i < 8; i++) begin
			drive_bit(value[i]);
		end
		drive_bit(1'b1);
	endtask

	initial begin
		int seed;
		int gap;
		int waited;
		int errors_before;
		int reply_len;
		clk = 1'b0;
		rst_n = 1'b0;
		rx = 1'b1;
		seed = 79179;
		pass_count = 0;
		fail_count = 0;
		timed_out = 1'b0;
		build_table();

		repeat (3) @(posedge clk);
		#2;
		rst_n = 1'b1;

		for (int t = 0; t < n_tests && !timed_out; t++) begin
			reply_len = exp_tab[t].size();
			u_checker.start_test(test_names[t]);
			for (int k = 0; k < reply_len; k++) begin
				u_checker.expect_byte(exp_tab[t][k]);
			end
			errors_before = u_checker.error_count;

			// Idle line between entries
			gap = 1 + ($unsigned($random(seed)) % 3);
			repeat (gap) drive_bit(1'b1);

			for (int k = 0; k < cmd_tab[t].size(); k++) begin
				send_byte(cmd_tab[t][k]);
			end

			waited = 0;
			while (u_checker.got_count < reply_len && waited < reply_timeout) begin
				@(posedge clk);
				#2;
				waited++;
			end

			if (u_checker.got_count < reply_len) begin
				$display("test %s: no reply within timeout", test_names[t]);
				timed_out = 1'b1;
				fail_count++;
			end else if (u_checker.error_count != errors_before) begin
				$display("test %s: wrong reply", test_names[t]);
				fail_count++;
			end else begin
				$display("test %s: ok", test_names[t]);
				pass_count++;
			end
		end

		$display("tests run %0d, ok %0d, bad %0d", pass_count + fail_count, pass_count,
			fail_count);
		if (fail_count == 0 && !timed_out) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

/* verification/debug_properties.sv */
`timescale 1ns/1ns

module debug_properties (
	input logic clk,
	input logic rst_n,
	input logic tx_start,
	input logic tx_done,
	input logic core_enable,
	input logic load_we
);

	logic tx_busy;

	// Byte in flight between tx_start and tx_done
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			tx_busy <= 1'b0;
		end else if (tx_start) begin
			tx_busy <= 1'b1;
		end else if (tx_done) begin
			tx_busy <= 1'b0;
		end
	end

	assert property (@(posedge clk) disable iff (!rst_n) tx_start |-> !tx_busy)
		else $error("tx_start raised while a byte is still being sent");

	// Core stays stopped while a reply goes out
	assert property (@(posedge clk) disable iff (!rst_n) core_enable |-> !tx_busy)
		else $error("core_enable high while a reply is being sent");

	assert property (@(posedge clk) disable iff (!rst_n) load_we |-> !tx_busy)
		else $error("load_we high while a reply is being sent");

endmodule

/* verification/debug_checker.sv */
`timescale 1ns/1ns

module debug_checker #(
	parameter int clks_per_bit = 8
) (
	input logic clk,
	input logic rst_n,
	input logic tx
);

	localparam int half_bit   = clks_per_bit / 2;
	localparam int stop_point = 9 * clks_per_bit + half_bit;

	logic [7:0] expected_q [$];
	string test_name = "none";
	int got_count = 0;
	int error_count = 0;

	logic active;
	int cnt;
	logic [7:0] shift;

	task automatic start_test(input string name);
		test_name = name;
		got_count = 0;
		expected_q.delete();
	endtask

	task automatic expect_byte(input logic [7:0] value);
		expected_q.push_back(value);
	endtask

	// Head of the expected list against one decoded byte
	task automatic compare_byte(input logic [7:0] actual);
		logic [7:0] expected;
		if (expected_q.size() == 0) begin
			$display("test %s: byte %02h sent on tx with no reply expected", test_name, actual);
			error_count++;
		end else begin
			expected = expected_q.pop_front();
			if (actual !== expected) begin
				$display("error %s expected %02h actual %02h", test_name, expected, actual);
				error_count++;
			end
		end
		got_count++;
	endtask

	//////////////////////////////
	// Serial decoder
	//////////////////////////////

	// Falling edge sampling keeps clear of the DUT's tx flop
	always @(negedge clk or negedge rst_n) begin
		if (!rst_n) begin
			active <= 1'b0;
			cnt    <= 0;
			shift  <= '0;
		end else if (!active) begin
			if (tx == 1'b0) begin
				active <= 1'b1;
				cnt    <= 0;
			end
		end else begin
			cnt <= cnt + 1;
			if (cnt == half_bit && tx !== 1'b0) begin
				$display("test %s: start bit on tx ended early", test_name);
				error_count++;
				active <= 1'b0;
			end else if (cnt > half_bit && cnt < stop_point &&
					(cnt - half_bit) % clks_per_bit == 0) begin
				// LSB first
				shift <= {tx, shift[7:1]};
			end else if (cnt == stop_point) begin
				active <= 1'b0;
				if (tx !== 1'b1) begin
					$display("test %s: stop bit on tx was not high", test_name);
					error_count++;
				end else begin
					compare_byte(shift);
				end
			end
		end
	end

endmodule

/* rtl/debug_top.sv */
`timescale 1ns/1ns

module debug_top #(
	parameter int clks_per_bit = 868,
	parameter int prog_depth   = 32
) (
	input  logic clk,
	input  logic rst_n,
	input  logic rx,
	output logic tx
);

	logic [7:0]                         rx_data;
	logic                               rx_done;
	logic                               halt;
	logic [debug_pkg::pc_width-1:0]     pc;
	logic [7:0]                         acc;
	logic [debug_pkg::reg_count*8-1:0]  regs_flat;
	logic                               core_enable;
	logic                               core_clear;
	logic                               load_we;
	logic [debug_pkg::pc_width-1:0]     load_addr;
	logic [7:0]                         load_data;
	logic                               capture;
	logic [2:0]                         dump_index;
	logic [7:0]                         dump_byte;
	logic                               tx_start;
	logic [7:0]                         tx_data;
	logic                               tx_done;

	//////////////////////////////
	// Serial side
	//////////////////////////////

	uart_rx #(
		.clks_per_bit(clks_per_bit)
	) u_uart_rx (
		.clk(clk),
		.rst_n(rst_n),
		.rx(rx),
		.rx_data(rx_data),
		.rx_done(rx_done)
	);

	uart_tx #(
		.clks_per_bit(clks_per_bit)
	) u_uart_tx (
		.clk(clk),
		.rst_n(rst_n),
		.tx_start(tx_start),
		.tx_data(tx_data),
		.tx(tx),
		.tx_done(tx_done)
	);

	//////////////////////////////
	// Debug unit and core
	//////////////////////////////

	debug_controller #(
		.prog_depth(prog_depth)
	) u_debug_controller (
		.clk(clk),
		.rst_n(rst_n),
		.rx_data(rx_data),
		.rx_done(rx_done),
		.halt(halt),
		.dump_byte(dump_byte),
		.tx_done(tx_done),
		.core_enable(core_enable),
		.core_clear(core_clear),
		.load_we(load_we),
		.load_addr(load_addr),
		.load_data(load_data),
		.capture(capture),
		.dump_index(dump_index),
		.tx_start(tx_start),
		.tx_data(tx_data)
	);

	state_collector u_state_collector (
		.clk(clk),
		.rst_n(rst_n),
		.capture(capture),
		.pc(pc),
		.acc(acc),
		.regs_flat(regs_flat),
		.dump_index(dump_index),
		.dump_byte(dump_byte)
	);

	acc_core #(
		.prog_depth(prog_depth)
	) u_acc_core (
		.clk(clk),
		.rst_n(rst_n),
		.core_enable(core_enable),
		.core_clear(core_clear),
		.load_we(load_we),
		.load_addr(load_addr),
		.load_data(load_data),
		.halt(halt),
		.pc(pc),
		.acc(acc),
		.regs_flat(regs_flat)
	);

endmodule

/* rtl/debug_controller.sv */
`timescale 1ns/1ns

module debug_controller #(
	parameter int prog_depth = 32
) (
	input  logic                           clk,
	input  logic                           rst_n,
	input  logic [7:0]                     rx_data,
	input  logic                           rx_done,
	input  logic                           halt,
	input  logic [7:0]                     dump_byte,
	input  logic                           tx_done,
	output logic                           core_enable,
	output logic                           core_clear,
	output logic                           load_we,
	output logic [debug_pkg::pc_width-1:0] load_addr,
	output logic [7:0]                     load_data,
	output logic                           capture,
	output logic [2:0]                     dump_index,
	output logic                           tx_start,
	output logic [7:0]                     tx_data
);

	// One extra bit so a full 32-word load can be counted
	localparam int cnt_w = debug_pkg::pc_width + 1;
	localparam logic [cnt_w-1:0] depth_max = cnt_w'(prog_depth);
	localparam logic [2:0] last_index = 3'(debug_pkg::dump_len - 1);

	typedef enum logic [2:0] {
		st_idle,
		st_load_count,
		st_load_data,
		st_run,
		st_step,
		st_send
	} state_t;

	state_t state;
	logic [cnt_w-1:0] load_total;
	logic [cnt_w-1:0] byte_cnt;
	logic [cnt_w-1:0] count_clamped;
	logic send_error;

	//////////////////////////////
	// Core and memory side
	//////////////////////////////

	assign core_enable = (state == st_run) || (state == st_step);
	assign load_we     = (state == st_load_data) && rx_done;
	assign load_addr   = byte_cnt[debug_pkg::pc_width-1:0];
	assign load_data   = rx_data;

	// Counts beyond the memory are cut down
	assign count_clamped = (rx_data > 8'(prog_depth)) ? depth_max : rx_data[cnt_w-1:0];

	assign tx_data = send_error ? debug_pkg::reply_error : dump_byte;

	//////////////////////////////
	// Command FSM
	//////////////////////////////

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state      <= st_idle;
			load_total <= '0;
			byte_cnt   <= '0;
			send_error <= 1'b0;
			dump_index <= '0;
			core_clear <= 1'b0;
			capture    <= 1'b0;
			tx_start   <= 1'b0;
		end else begin
			core_clear <= 1'b0;
			capture    <= 1'b0;
			tx_start   <= 1'b0;
			case (state)
				st_idle: begin
					if (rx_done) begin
						case (rx_data)
							debug_pkg::cmd_load: begin
								state      <= st_load_count;
								core_clear <= 1'b1;
							end
							debug_pkg::cmd_run:  state <= st_run;
							debug_pkg::cmd_step: state <= st_step;
							default: begin
								state      <= st_send;
								send_error <= 1'b1;
								tx_start   <= 1'b1;
							end
						endcase
					end
				end
				st_load_count: begin
					if (rx_done) begin
						load_total <= count_clamped;
						byte_cnt   <= '0;
						state      <= (count_clamped == '0) ? st_idle : st_load_data;
					end
				end
				st_load_data: begin
					if (rx_done) begin
						byte_cnt <= byte_cnt + 1'b1;
						if (byte_cnt + 1'b1 == load_total) begin
							state <= st_idle;
						end
					end
				end
				st_run: begin
					if (halt) begin
						state      <= st_send;
						capture    <= 1'b1;
						dump_index <= '0;
						send_error <= 1'b0;
					end
				end
				st_step: begin
					// Exactly one enabled cycle
					state      <= st_send;
					capture    <= 1'b1;
					dump_index <= '0;
					send_error <= 1'b0;
				end
				default: begin
					// First byte once the snapshot is taken
					if (capture) begin
						tx_start <= 1'b1;
					end
					if (tx_done) begin
						if (send_error || dump_index == last_index) begin
							state <= st_idle;
						end else begin
							dump_index <= dump_index + 1'b1;
							tx_start   <= 1'b1;
						end
					end
				end
			endcase
		end
	end

endmodule

/* rtl/state_collector.sv */
`timescale 1ns/1ns

module state_collector (
	input  logic                               clk,
	input  logic                               rst_n,
	input  logic                               capture,
	input  logic [debug_pkg::pc_width-1:0]     pc,
	input  logic [7:0]                         acc,
	input  logic [debug_pkg::reg_count*8-1:0]  regs_flat,
	input  logic [2:0]                         dump_index,
	output logic [7:0]                         dump_byte
);

	logic [debug_pkg::pc_width-1:0]     snap_pc;
	logic [7:0]                         snap_acc;
	logic [debug_pkg::reg_count*8-1:0]  snap_regs;
	logic [1:0]                         reg_sel;

	// Snapshot holds still while the dump goes out
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			snap_pc   <= '0;
			snap_acc  <= '0;
			snap_regs <= '0;
		end else if (capture) begin
			snap_pc   <= pc;
			snap_acc  <= acc;
			snap_regs <= regs_flat;
		end
	end

	// Registers start at dump index 2
	assign reg_sel = dump_index[1:0] - 2'd2;

	always_comb begin
		if (dump_index == 3'd0) begin
			dump_byte = {{(8 - debug_pkg::pc_width){1'b0}}, snap_pc};
		end else if (dump_index == 3'd1) begin
			dump_byte = snap_acc;
		end else if (dump_index < 3'(debug_pkg::dump_len)) begin
			dump_byte = snap_regs[{reg_sel, 3'b000} +: 8];
		end else begin
			dump_byte = 8'd0;
		end
	end

endmodule

/* rtl/acc_core.sv */
`timescale 1ns/1ns

module acc_core #(
	parameter int prog_depth = 32
) (
	input  logic                               clk,
	input  logic                               rst_n,
	input  logic                               core_enable,
	input  logic                               core_clear,
	input  logic                               load_we,
	input  logic [debug_pkg::pc_width-1:0]     load_addr,
	input  logic [7:0]                         load_data,
	output logic                               halt,
	output logic [debug_pkg::pc_width-1:0]     pc,
	output logic [7:0]                         acc,
	output logic [debug_pkg::reg_count*8-1:0]  regs_flat
);

	logic [7:0] imem [prog_depth];
	logic [7:0] regs [debug_pkg::reg_count];

	logic [7:0] instr;
	logic [2:0] opcode;
	logic [4:0] operand;
	logic [1:0] rsel;

	//////////////////////////////
	// Instruction memory
	//////////////////////////////

	// Written only by the debug unit
	always_ff @(posedge clk) begin
		if (load_we) begin
			imem[load_addr] <= load_data;
		end
	end

	assign instr   = imem[pc];
	assign opcode  = instr[7:5];
	assign operand = instr[4:0];
	assign rsel    = operand[1:0];

	//////////////////////////////
	// Execute
	//////////////////////////////

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pc   <= '0;
			acc  <= '0;
			halt <= 1'b0;
			for (int i = 0; i < debug_pkg::reg_count; i++) begin
				regs[i] <= '0;
			end
		end else if (core_clear || load_we) begin
			// Every load restarts the program from scratch
			pc   <= '0;
			acc  <= '0;
			halt <= 1'b0;
			for (int i = 0; i < debug_pkg::reg_count; i++) begin
				regs[i] <= '0;
			end
		end else if (core_enable && !halt) begin
			pc <= pc + 1'b1;
			case (opcode)
				debug_pkg::op_halt: begin
					halt <= 1'b1;
					pc   <= pc;
				end
				debug_pkg::op_ldi: acc <= {3'b000, operand};
				debug_pkg::op_add: acc <= acc + regs[rsel];
				debug_pkg::op_sub: acc <= acc - regs[rsel];
				debug_pkg::op_str: regs[rsel] <= acc;
				debug_pkg::op_jnz: begin
					if (acc != 8'd0) begin
						pc <= operand[debug_pkg::pc_width-1:0];
					end
				end
				// Unused opcodes just advance
				default: ;
			endcase
		end
	end

	// r0 in the low byte
	always_comb begin
		for (int i = 0; i < debug_pkg::reg_count; i++) begin
			regs_flat[8*i +: 8] = regs[i];
		end
	end

endmodule

/* uart/uart_tx.sv */
`timescale 1ns/1ns

module uart_tx #(
	parameter int clks_per_bit = 868
) (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       tx_start,
	input  logic [7:0] tx_data,
	output logic       tx,
	output logic       tx_done
);

	localparam int cnt_w = $clog2(clks_per_bit);
	localparam logic [cnt_w-1:0] last_cnt = cnt_w'(clks_per_bit - 1);

	logic busy;
	logic [cnt_w-1:0] cnt;
	logic [3:0] bit_idx;
	// Data bits followed by the stop bit
	logic [8:0] shreg;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			busy    <= 1'b0;
			cnt     <= '0;
			bit_idx <= '0;
			shreg   <= '1;
			tx      <= 1'b1;
			tx_done <= 1'b0;
		end else begin
			tx_done <= 1'b0;
			if (!busy) begin
				if (tx_start) begin
					// Start bit goes out right away
					busy    <= 1'b1;
					cnt     <= '0;
					bit_idx <= '0;
					shreg   <= {1'b1, tx_data};
					tx      <= 1'b0;
				end
			end else if (cnt == last_cnt) begin
				cnt <= '0;
				if (bit_idx == 4'd9) begin
					// End of stop bit
					busy    <= 1'b0;
					tx      <= 1'b1;
					tx_done <= 1'b1;
				end else begin
					tx      <= shreg[0];
					shreg   <= {1'b1, shreg[8:1]};
					bit_idx <= bit_idx + 1'b1;
				end
			end else begin
				cnt <= cnt + 1'b1;
			end
		end
	end

endmodule

/* uart/uart_rx.sv */
`timescale 1ns/1ns

module uart_rx #(
	parameter int clks_per_bit = 868
) (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       rx,
	output logic [7:0] rx_data,
	output logic       rx_done
);

	localparam int cnt_w = $clog2(clks_per_bit);
	localparam logic [cnt_w-1:0] last_cnt = cnt_w'(clks_per_bit - 1);
	localparam logic [cnt_w-1:0] half_cnt = cnt_w'(clks_per_bit / 2 - 1);

	typedef enum logic [1:0] {
		s_idle,
		s_start,
		s_data,
		s_stop
	} rx_state_t;

	rx_state_t state;
	logic rx_meta;
	logic rx_sync;
	logic [cnt_w-1:0] cnt;
	logic [2:0] bit_idx;
	logic sample_data;

	// Two flop synchroniser, line idles high
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
		end else begin
			rx_meta <= rx;
			rx_sync <= rx_meta;
		end
	end

	assign sample_data = (state == s_data) && (cnt == last_cnt);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state   <= s_idle;
			cnt     <= '0;
			bit_idx <= '0;
			rx_done <= 1'b0;
		end else begin
			rx_done <= 1'b0;
			case (state)
				s_idle: begin
					if (!rx_sync) begin
						cnt   <= '0;
						state <= s_start;
					end
				end
				s_start: begin
					// Start bit must still be low at mid-bit
					if (cnt == half_cnt) begin
						cnt     <= '0;
						bit_idx <= '0;
						state   <= rx_sync ? s_idle : s_data;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				s_data: begin
					if (cnt == last_cnt) begin
						cnt <= '0;
						if (bit_idx == 3'd7) begin
							state <= s_stop;
						end else begin
							bit_idx <= bit_idx + 1'b1;
						end
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				default: begin
					if (cnt == last_cnt) begin
						state   <= s_idle;
						// Framing error drops the byte
						rx_done <= rx_sync;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
			endcase
		end
	end

	// LSB first
	always_ff @(posedge clk) begin
		if (sample_data) begin
			rx_data <= {rx_sync, rx_data[7:1]};
		end
	end

endmodule

/* common/debug_pkg.sv */
package debug_pkg;

	//////////////////////////////
	// Core geometry
	//////////////////////////////

	// pc and instruction memory address width
	localparam int pc_width = 5;

	// General registers r0 to r3
	localparam int reg_count = 4;

	// Opcodes live in instruction bits 7 to 5
	localparam logic [2:0] op_halt = 3'd0;
	localparam logic [2:0] op_ldi  = 3'd1;
	localparam logic [2:0] op_add  = 3'd2;
	localparam logic [2:0] op_sub  = 3'd3;
	localparam logic [2:0] op_str  = 3'd4;
	localparam logic [2:0] op_jnz  = 3'd5;

	//////////////////////////////
	// Host protocol
	//////////////////////////////

	localparam logic [7:0] cmd_load = 8'h4C;
	localparam logic [7:0] cmd_run  = 8'h52;
	localparam logic [7:0] cmd_step = 8'h53;

	// Reply to an unknown command
	localparam logic [7:0] reply_error = 8'hEE;

	// pc, acc, r0, r1, r2, r3
	localparam int dump_len = 6;

endpackage
